// ==== bench/sa_clkgen.sv ====
`timescale 1ns/10ps

// Free-running clock for the testbench
module sa_clkgen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;   // 50 % duty cycle
        end
    end

endmodule

// ==== bench/sa_tb.sv ====
`timescale 1ns/10ps

module sa_tb;

    localparam int ROWS     = sa_pkg::DEF_ROWS;
    localparam int COLS     = sa_pkg::DEF_COLS;
    localparam int BATCH    = 8;            // Steps in a random batch
    localparam int SETTLE   = ROWS + COLS;  // Idle cycles before a drain
    localparam int GAP      = 3;            // Idle cycles inside a gapped batch
    localparam int EXTREME  = 40;           // Enough -128 products to wrap 20 bits
    localparam int ACC_BITS = 20;
    localparam int ACC_MOD  = 1 << ACC_BITS;
    localparam int ACC_HALF = 1 << (ACC_BITS - 1);

    // Cycle budget of each test
    localparam int RST_CYC = 4;
    localparam int T1_CYC  = BATCH + SETTLE + ROWS;
    localparam int T2_CYC  = 2 * (BATCH + SETTLE + ROWS) + 2 * GAP;
    localparam int T3_CYC  = BATCH + 4 + EXTREME + SETTLE + ROWS;
    localparam int T4_CYC  = BATCH + SETTLE + 2 * ROWS;
    localparam int T5_CYC  = 3 * (BATCH + SETTLE) + 2 + 2 * ROWS;
    localparam int T6_CYC  = 5 + 2 + 1 + BATCH + SETTLE + ROWS;
    localparam int CYCLE_LIMIT =
        2 * (RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC + 2);

    logic                           clk;
    logic                           cnt_rst;
    logic                           en;
    logic                           clear;
    logic                           drain;
    sa_pkg::weight_t     [ROWS-1:0] row_in;
    sa_pkg::pixel_pair_t [COLS-1:0] column_in;
    sa_pkg::pe_sum_t     [COLS-1:0] out;

    logic   sample_out;       // Comparer looks at out this cycle
    integer seed;
    int     errors    = 0;
    int     checks    = 0;
    int     cycle_cnt = 0;

    // Expected sums per row, column and lane
    int model_hi [ROWS][COLS];
    int model_lo [ROWS][COLS];

    sa_pkg::weight_t     [ROWS-1:0] batch_w [BATCH];
    sa_pkg::pixel_pair_t [COLS-1:0] batch_p [BATCH];
    sa_pkg::weight_t     [ROWS-1:0] ext_w;
    sa_pkg::pixel_pair_t [COLS-1:0] ext_p;

    sa_clkgen #(
        .PERIOD_NS (10)
    ) clkgen0 (
        .clk (clk)
    );

    sa_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) dut0 (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .en        (en),
        .clear     (clear),
        .drain     (drain),
        .row_in    (row_in),
        .column_in (column_in),
        .out       (out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Running sum after one more product, kept to a signed 20-bit range
    function automatic int wrap_mac(input int acc, input int w, input int p);
        int s;
        s = (acc + w * p) & (ACC_MOD - 1);
        if (s >= ACC_HALF) begin
            s = s - ACC_MOD;
        end
        return s;
    endfunction

    // Every PE(i,j) sees weight i and pixel pair j of the same step
    function automatic void model_step(input sa_pkg::weight_t     [ROWS-1:0] w,
                                       input sa_pkg::pixel_pair_t [COLS-1:0] p);
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < COLS; j++) begin
                model_hi[i][j] = wrap_mac(model_hi[i][j], int'(w[i]), int'(p[j].hi));
                model_lo[i][j] = wrap_mac(model_lo[i][j], int'(w[i]), int'(p[j].lo));
            end
        end
    endfunction

    function automatic void model_zero();
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < COLS; j++) begin
                model_hi[i][j] = 0;
                model_lo[i][j] = 0;
            end
        end
    endfunction

    // One drain edge: every row moves down, zeros enter at the top
    function automatic void model_shift();
        for (int i = ROWS - 1; i > 0; i--) begin
            model_hi[i] = model_hi[i-1];
            model_lo[i] = model_lo[i-1];
        end
        for (int j = 0; j < COLS; j++) begin
            model_hi[0][j] = 0;
            model_lo[0][j] = 0;
        end
    endfunction

    // out always shows the bottom row
    function automatic int expected_out(input int j, input bit lane_hi);
        return lane_hi ? model_hi[ROWS-1][j] : model_lo[ROWS-1][j];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Comparison and timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (sample_out) begin
            for (int j = 0; j < COLS; j++) begin
                checks = checks + 2;
                assert (out[j].hi === sa_pkg::acc_t'(expected_out(j, 1'b1))) else begin
                    errors = errors + 1;
                    $display("[ERROR] t=%0d ns out[%0d].hi expected %0d got %0d",
                             $time, j, expected_out(j, 1'b1), out[j].hi);
                end
                assert (out[j].lo === sa_pkg::acc_t'(expected_out(j, 1'b0))) else begin
                    errors = errors + 1;
                    $display("[ERROR] t=%0d ns out[%0d].lo expected %0d got %0d",
                             $time, j, expected_out(j, 1'b0), out[j].lo);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the test sequence did not finish within %0d cycles",
                     CYCLE_LIMIT);
            $display("Done: %0d output checks, %0d errors", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_random_batch();
        int r;
        for (int s = 0; s < BATCH; s++) begin
            for (int i = 0; i < ROWS; i++) begin
                r = $random(seed);
                batch_w[s][i] = r[7:0];
            end
            for (int j = 0; j < COLS; j++) begin
                r = $random(seed);
                batch_p[s][j] = r[15:0];
            end
        end
    endtask

    task automatic drive_step(input sa_pkg::weight_t     [ROWS-1:0] w,
                              input sa_pkg::pixel_pair_t [COLS-1:0] p);
        en        = 1'b1;
        row_in    = w;
        column_in = p;
        model_step(w, p);
        next_cycle();
    endtask

    // Operands keep changing with en low, the DUT must ignore them
    task automatic idle(input int n);
        int r;
        en = 1'b0;
        for (int c = 0; c < n; c++) begin
            for (int i = 0; i < ROWS; i++) begin
                r = $random(seed);
                row_in[i] = r[7:0];
            end
            for (int j = 0; j < COLS; j++) begin
                r = $random(seed);
                column_in[j] = r[15:0];
            end
            next_cycle();
        end
    endtask

    // gap > 0 puts idle cycles after steps 2 and 5
    task automatic run_batch(input int steps, input int gap);
        for (int s = 0; s < steps; s++) begin
            drive_step(batch_w[s], batch_p[s]);
            if (gap > 0 && s % 3 == 2 && s != steps - 1) begin
                idle(gap);
            end
        end
    endtask

    task automatic drain_rows();
        drain      = 1'b1;
        sample_out = 1'b1;
        for (int n = 0; n < ROWS; n++) begin
            next_cycle();
            model_shift();   // DUT shifted at the edge just passed
        end
        drain      = 1'b0;
        sample_out = 1'b0;
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        model_zero();
        next_cycle();
        clear = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed       = 32'h1ccb_5311;
        cnt_rst    = 1'b1;
        en         = 1'b0;
        clear      = 1'b0;
        drain      = 1'b0;
        sample_out = 1'b0;
        row_in     = '0;
        column_in  = '0;
        model_zero();
        for (int i = 0; i < ROWS; i++) begin
            ext_w[i] = 8'h80;
        end
        for (int j = 0; j < COLS; j++) begin
            ext_p[j].hi = 8'h80;   // -128 x -128
            ext_p[j].lo = 8'h7f;   // -128 x 127
        end
        repeat (RST_CYC) @(posedge clk);
        #1;
        cnt_rst = 1'b0;

        // One random batch
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        drain_rows();

        // Gapped batch, then the same steps back to back
        fill_random_batch();
        run_batch(BATCH, GAP);
        idle(SETTLE);
        drain_rows();
        run_batch(BATCH, 0);
        idle(SETTLE);
        drain_rows();

        // Two batches with no clear, the second one wraps the sums
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(4);
        repeat (EXTREME) drive_step(ext_w, ext_p);
        idle(SETTLE);
        drain_rows();

        // Back-to-back drains, the second reads zeros
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        drain_rows();
        drain_rows();

        // Clear before a drain, and clear before a new batch
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        pulse_clear();
        drain_rows();
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        pulse_clear();
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        drain_rows();

        // Reset while a batch is in flight
        fill_random_batch();
        run_batch(5, 0);
        en      = 1'b0;
        cnt_rst = 1'b1;
        model_zero();
        repeat (2) next_cycle();
        cnt_rst    = 1'b0;
        sample_out = 1'b1;   // Sums read zero straight after reset
        next_cycle();
        sample_out = 1'b0;
        fill_random_batch();
        run_batch(BATCH, 0);
        idle(SETTLE);
        drain_rows();

        idle(2);
        $display("Done: %0d output checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the systolic array testbench with Verilator and runs it
# Success only when the simulation prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module sa_tb --Mdir obj_dir -o sa_sim -f sources.f || {
    echo "Build failed"
    exit 1
}

./obj_dir/sa_sim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" && {
    echo "Simulation passed"
    exit 0
} || {
    echo "Simulation failed"
    exit 1
}

// ==== sources.f ====
src/sa_pkg.sv
src/sa_skew.sv
src/sa_pe.sv
src/sa_array.sv
src/sa_top.sv
bench/sa_clkgen.sv
bench/sa_tb.sv

// ==== src/sa_array.sv ====
`timescale 1ns/10ps

module sa_array #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                           clk,
    input  logic                           cnt_rst,
    input  logic                           clear,
    input  logic                           drain,
    input  sa_pkg::row_flow_t   [ROWS-1:0] row_in,
    input  sa_pkg::pixel_pair_t [COLS-1:0] column_in,
    output sa_pkg::pe_sum_t     [COLS-1:0] out
);

    // row_w[i][j] enters PE(i,j) from the left
    // row_w[i][COLS] is what leaves the right edge
    sa_pkg::row_flow_t   row_w [ROWS][COLS+1];
    // pix_w[i][j] and sum_w[i][j] enter PE(i,j) from above
    sa_pkg::pixel_pair_t pix_w [ROWS+1][COLS];
    sa_pkg::pe_sum_t     sum_w [ROWS+1][COLS];

    logic [ROWS-1:0][COLS:0] valid_map;   // Every valid bit on the row wires

    ////////////////////////////////////////////////////////////////////////////
    // Edge wiring
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ROWS; i++) begin : g_left
        assign row_w[i][0] = row_in[i];
        for (genvar j = 0; j <= COLS; j++) begin : g_vmap
            assign valid_map[i][j] = row_w[i][j].valid;
        end
    end

    for (genvar j = 0; j < COLS; j++) begin : g_top
        assign pix_w[0][j] = column_in[j];
        assign sum_w[0][j] = '0;             // Zeros fill in from the top while draining
        assign out[j]      = sum_w[ROWS][j]; // Bottom row registers
    end

    ////////////////////////////////////////////////////////////////////////////
    // PE grid
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        for (genvar j = 0; j < COLS; j++) begin : g_col
            sa_pe u_pe (
                .clk     (clk),
                .cnt_rst (cnt_rst),
                .clear   (clear),
                .drain   (drain),
                .row_in  (row_w[i][j]),
                .row_out (row_w[i][j+1]),
                .pix_in  (pix_w[i][j]),
                .pix_out (pix_w[i+1][j]),
                .sum_in  (sum_w[i][j]),
                .sum_out (sum_w[i+1][j])
            );
        end
    end

    // No back-pressure, so draining over a live step would lose products
    a_drain_idle: assert property (
        @(posedge clk) disable iff (cnt_rst)
        drain |-> !(|valid_map)
    ) else $error("sa_array drain while a step is still in flight");

endmodule

// ==== src/sa_pe.sv ====
`timescale 1ns/10ps

module sa_pe (
    input  logic                clk,
    input  logic                cnt_rst,
    input  logic                clear,
    input  logic                drain,
    input  sa_pkg::row_flow_t   row_in,
    output sa_pkg::row_flow_t   row_out,
    input  sa_pkg::pixel_pair_t pix_in,
    output sa_pkg::pixel_pair_t pix_out,
    input  sa_pkg::pe_sum_t     sum_in,
    output sa_pkg::pe_sum_t     sum_out
);

    sa_pkg::acc_t    prod_hi;
    sa_pkg::acc_t    prod_lo;
    sa_pkg::pe_sum_t sum_q;

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////////////////////

    // Row flow carries the valid bit, so it is cleared on reset
    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            row_out <= '0;
        end else begin
            row_out <= row_in;
        end
    end

    always_ff @(posedge clk) begin
        pix_out <= pix_in;   // Toward the PE below
    end

    ////////////////////////////////////////////////////////////////////////////
    // Dual-lane multiply-accumulate
    ////////////////////////////////////////////////////////////////////////////

    // 8x8 signed product fits in 16 bits
    // sign extension to 20 leaves the headroom bits for the running sum
    assign prod_hi = sa_pkg::acc_t'($signed(row_in.weight))
                   * sa_pkg::acc_t'($signed(pix_in.hi));
    assign prod_lo = sa_pkg::acc_t'($signed(row_in.weight))
                   * sa_pkg::acc_t'($signed(pix_in.lo));

    always_ff @(posedge clk) begin
        if (cnt_rst || clear) begin
            sum_q <= '0;
        end else if (drain) begin
            sum_q <= sum_in;              // Take the sums of the PE above
        end else if (row_in.valid) begin
            sum_q.hi <= sum_q.hi + prod_hi;   // Wraps at 20 bits
            sum_q.lo <= sum_q.lo + prod_lo;
        end
    end

    assign sum_out = sum_q;

endmodule

// ==== src/sa_pkg.sv ====
package sa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int DEF_ROWS = 4;  // Array height used by top and bench
    localparam int DEF_COLS = 4;  // Array width used by top and bench

    localparam int OPND_W   = 8;                  // Weight and pixel width
    localparam int HEADROOM = 4;                  // Guard bits above the product
    localparam int ACC_W    = 2 * OPND_W + HEADROOM;

    ////////////////////////////////////////////////////////////////////////////
    // Operand and accumulator types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [OPND_W-1:0] weight_t;
    typedef logic signed [OPND_W-1:0] pixel_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Two pixels share one 16-bit column word
    typedef struct packed {
        pixel_t hi;
        pixel_t lo;
    } pixel_pair_t;

    // One running sum per pixel lane
    typedef struct packed {
        acc_t hi;
        acc_t lo;
    } pe_sum_t;

    // What moves left to right along a row
    typedef struct packed {
        logic    valid;   // Step is live, accumulate on arrival
        weight_t weight;
    } row_flow_t;

endpackage

// ==== src/sa_skew.sv ====
`timescale 1ns/10ps

// Lane n is delayed by n cycles so that an aligned vector leaves as a diagonal
module sa_skew #(
    parameter int  LANES  = 4,
    parameter type lane_t = logic [7:0]
) (
    input  logic              clk,
    input  logic              cnt_rst,
    input  lane_t [LANES-1:0] lane_in,
    output lane_t [LANES-1:0] lane_out
);

    for (genvar n = 0; n < LANES; n++) begin : g_lane

        if (n == 0) begin : g_pass
            assign lane_out[0] = lane_in[0];  // First lane needs no delay

        end else begin : g_dly
            // stg[0] is the entry stage, stg[n-1] drives the output
            lane_t [n-1:0] stg;

            always_ff @(posedge clk) begin
                if (cnt_rst) begin
                    stg <= '0;   // Also kills any valid bit in flight
                end else begin
                    stg[0] <= lane_in[n];
                    for (int k = 1; k < n; k++) begin
                        stg[k] <= stg[k-1];
                    end
                end
            end

            assign lane_out[n] = stg[n-1];

            // A stage that goes unknown would smear X across a whole diagonal
            a_stage_known: assert property (
                @(posedge clk) disable iff (cnt_rst)
                !$isunknown(stg)
            ) else $error("sa_skew lane %0d holds an unknown stage value", n);
        end

    end

endmodule

// ==== src/sa_top.sv ====
`timescale 1ns/10ps

module sa_top #(
    parameter int ROWS = sa_pkg::DEF_ROWS,
    parameter int COLS = sa_pkg::DEF_COLS
) (
    input  logic                           clk,
    input  logic                           cnt_rst,
    input  logic                           en,
    input  logic                           clear,
    input  logic                           drain,
    input  sa_pkg::weight_t     [ROWS-1:0] row_in,
    input  sa_pkg::pixel_pair_t [COLS-1:0] column_in,
    output sa_pkg::pe_sum_t     [COLS-1:0] out
);

    sa_pkg::row_flow_t   [ROWS-1:0] row_flow;    // Aligned, en attached
    sa_pkg::row_flow_t   [ROWS-1:0] row_skewed;
    sa_pkg::pixel_pair_t [COLS-1:0] col_skewed;

    // Each weight carries its own copy of en down the skew
    for (genvar i = 0; i < ROWS; i++) begin : g_pack
        assign row_flow[i].valid  = en;
        assign row_flow[i].weight = row_in[i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input skew
    ////////////////////////////////////////////////////////////////////////////

    sa_skew #(
        .LANES  (ROWS),
        .lane_t (sa_pkg::row_flow_t)
    ) row_skew (
        .clk      (clk),
        .cnt_rst  (cnt_rst),
        .lane_in  (row_flow),
        .lane_out (row_skewed)
    );

    sa_skew #(
        .LANES  (COLS),
        .lane_t (sa_pkg::pixel_pair_t)
    ) col_skew (
        .clk      (clk),
        .cnt_rst  (cnt_rst),
        .lane_in  (column_in),
        .lane_out (col_skewed)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Array
    ////////////////////////////////////////////////////////////////////////////

    sa_array #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_array (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .clear     (clear),
        .drain     (drain),
        .row_in    (row_skewed),
        .column_in (col_skewed),
        .out       (out)
    );

endmodule
